// File: rtl/agu_pkg.sv
// address unit shared definitions
package agu_pkg;

  localparam int VADDR_BITS = 44;
  localparam int PAGE_BITS  = 13;
  localparam int LINE_BITS  = 8;
  localparam int BANK_COUNT = 32;

  typedef logic [VADDR_BITS-1:0]           vaddr_t;
  typedef logic [VADDR_BITS-PAGE_BITS-1:0] vpage_t;
  typedef logic [VADDR_BITS-PAGE_BITS-1:0] ppage_t;
  typedef logic [VADDR_BITS-LINE_BITS-1:0] line_addr_t;
  typedef logic [BANK_COUNT-1:0]           bank_mask_t;
  typedef logic [$clog2(BANK_COUNT)-1:0]   bank_t;
  typedef logic [4:0]                      size_code_t;
  typedef logic [8:0]                      reg_tag_t;
  typedef logic [1:0]                      op_type_t;
  typedef logic [7:0]                      fault_code_t;
  typedef logic [8:0]                      fault_no_t;
  typedef logic [2:0]                      bank_cnt_t;

  localparam op_type_t  OP_TYPE_IO    = 2'd2;
  localparam fault_no_t FAULT_NO_PAGE = 9'd45;
  localparam fault_no_t FAULT_NO_NONE = 9'd2;

  // access width class, decides how far past bank0 an access reaches
  typedef enum logic [2:0] {
    CLS_0,
    CLS_1,
    CLS_2,
    CLS_3,
    CLS_4,
    CLS_5,
    CLS_6
  } size_class_t;

  function automatic size_class_t size_class(input size_code_t sz);
    case (sz)
      5'd16: return CLS_0;
      5'd17: return CLS_1;
      5'd18: return CLS_2;
      5'd19: return CLS_3;
      // extended precision
      5'd3: return CLS_4;
      // 128 bit forms
      5'd0, 5'd1, 5'd2, 5'd12, 5'd13, 5'd14: return CLS_5;
      5'd4, 5'd5, 5'd6: return CLS_2;
      5'd8, 5'd9, 5'd10: return CLS_3;
      // fill and spill
      5'd15: return CLS_6;
      default: return CLS_3;
    endcase
  endfunction

  // banks touched beyond bank0, given the low two address bits
  function automatic bank_cnt_t extra_banks(input size_class_t cls, input logic [1:0] low);
    logic step_over;
    logic step_over2;
    step_over  = |low;
    step_over2 = &low;
    case (cls)
      CLS_0: return 3'd0;
      CLS_1: return step_over2 ? 3'd1 : 3'd0;
      CLS_2: return step_over ? 3'd1 : 3'd0;
      CLS_3: return step_over ? 3'd2 : 3'd1;
      CLS_4: return step_over2 ? 3'd3 : 3'd2;
      CLS_5: return step_over ? 3'd4 : 3'd3;
      // CLS_6 always spans five banks
      default: return 3'd4;
    endcase
  endfunction

endpackage

// File: rtl/agu_op_if.sv
// registered micro-op bundle
`timescale 1ns/1ns
interface agu_op_if #(
  parameter int TAG_WIDTH = $bits(agu_pkg::reg_tag_t)
) ();

  logic                   valid;
  agu_pkg::vaddr_t        addr;
  agu_pkg::size_code_t    sz;
  logic                   st;
  agu_pkg::bank_t         bank0;
  logic [TAG_WIDTH-1:0]   tag;
  logic                   kernel;
  agu_pkg::op_type_t      op_type;

  // stage register side
  modport ctl (
    output valid, addr, sz, st, bank0, tag, kernel, op_type
  );

  // decode, translate and issue side
  modport user (
    input valid, addr, sz, st, bank0, tag, kernel, op_type
  );

endinterface

// File: rtl/agu_op_reg.sv
// micro-op stage register
`timescale 1ns/1ns
module agu_op_reg #(
  parameter int TAG_WIDTH = $bits(agu_pkg::reg_tag_t)
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 except,
  input  logic                 stall,
  input  logic                 op_en,
  input  agu_pkg::vaddr_t      op_addr,
  input  agu_pkg::size_code_t  op_sz,
  input  logic                 op_st,
  input  agu_pkg::bank_t       op_bank0,
  input  logic [TAG_WIDTH-1:0] op_tag,
  input  logic                 op_kernel,
  input  agu_pkg::op_type_t    op_type,
  input  logic                 issued,
  agu_op_if.ctl                op
);
  import agu_pkg::*;

  logic                 accept;
  logic                 valid_q;
  vaddr_t               addr_q;
  size_code_t           sz_q;
  logic                 st_q;
  bank_t                bank0_q;
  logic [TAG_WIDTH-1:0] tag_q;
  logic                 kernel_q;
  op_type_t             op_type_q;

  // a new op enters only while nothing holds the stage
  assign accept = op_en & ~stall & ~except;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (except | issued) begin
      // empties after issue unless refilled at the same edge
      valid_q <= 1'b0;
    end
  end

  // op fields, held until the next accept
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q    <= op_addr;
      sz_q      <= op_sz;
      st_q      <= op_st;
      bank0_q   <= op_bank0;
      tag_q     <= op_tag;
      kernel_q  <= op_kernel;
      op_type_q <= op_type;
    end
  end

  assign op.valid   = valid_q;
  assign op.addr    = addr_q;
  assign op.sz      = sz_q;
  assign op.st      = st_q;
  assign op.bank0   = bank0_q;
  assign op.tag     = tag_q;
  assign op.kernel  = kernel_q;
  assign op.op_type = op_type_q;

endmodule

// File: rtl/agu_bank_decode.sv
// cache bank mask decode
`timescale 1ns/1ns
module agu_bank_decode (
  agu_op_if.user              op,
  output agu_pkg::bank_mask_t banks
);
  import agu_pkg::*;

  size_class_t cls;
  bank_cnt_t   extra;

  always_comb begin
    cls   = size_class(op.sz);
    extra = extra_banks(cls, op.addr[1:0]);
  end

  // bank i is touched when it lies within extra banks after bank0
  // the 5 bit difference wraps past bank 31 by itself
  always_comb begin
    for (int i = 0; i < BANK_COUNT; i++) begin
      banks[i] = (bank_t'(i) - op.bank0) <= bank_t'(extra);
    end
  end

endmodule

// File: rtl/agu_translate.sv
// line address build and page checks
`timescale 1ns/1ns
module agu_translate (
  agu_op_if.user              op,
  output agu_pkg::vpage_t     tlb_vpage,
  output agu_pkg::vpage_t     tlb_next_vpage,
  input  logic                tlb_hit,
  input  agu_pkg::ppage_t     tlb_phys,
  input  logic                tlb_sys,
  input  logic                tlb_na,
  input  logic                tlb_next_hit,
  input  agu_pkg::ppage_t     tlb_next_phys,
  input  logic                tlb_next_sys,
  input  logic                tlb_next_na,
  output agu_pkg::line_addr_t addr_even,
  output agu_pkg::line_addr_t addr_odd,
  output logic [1:0]          addr_low,
  output logic                odd,
  output logic                split,
  output logic                ready,
  output logic [1:0]          fault
);
  import agu_pkg::*;

  logic [PAGE_BITS-LINE_BITS:0] m;
  logic [PAGE_BITS-LINE_BITS:0] n;
  logic                         carry;
  logic [5:0]                   end_bank;
  bank_cnt_t                    extra;
  logic                         need_next;
  ppage_t                       next_page;
  line_addr_t                   main_line;
  line_addr_t                   next_line;
  logic [1:0]                   fault_main;
  logic [1:0]                   fault_next;

  assign tlb_vpage      = op.addr[VADDR_BITS-1:PAGE_BITS];
  assign tlb_next_vpage = tlb_vpage + 1'b1;

  // split when the bank run wraps past bank 31 into the other half line
  assign extra    = extra_banks(size_class(op.sz), op.addr[1:0]);
  assign end_bank = {1'b0, op.bank0} + 6'(extra);
  assign split    = end_bank[5];

  // half-line index within the page and its successor
  assign m          = op.addr[PAGE_BITS-1:LINE_BITS-1];
  assign {carry, n} = {1'b0, m} + 7'd1;
  assign need_next  = split & carry;

  assign next_page = need_next ? tlb_next_phys : tlb_phys;
  assign main_line = {tlb_phys, m[5:1]};
  assign next_line = {next_page, n[5:1]};

  assign odd      = op.addr[LINE_BITS-1];
  assign addr_low = op.addr[1:0];

  // the op's own half goes to its parity, the other half is the next line
  assign addr_even = odd ? next_line : main_line;
  assign addr_odd  = odd ? main_line : next_line;

  assign ready = tlb_hit & (~need_next | tlb_next_hit);

  // privilege in bit 1, not-present in bit 0
  assign fault_main = {~op.kernel & tlb_sys, ~tlb_na};
  assign fault_next = {~op.kernel & tlb_next_sys, ~tlb_next_na};
  assign fault      = fault_main | (need_next ? fault_next : 2'b00);

endmodule

// File: rtl/agu_issue.sv
// issue control and fault report
`timescale 1ns/1ns
module agu_issue (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 except,
  input  logic                 bus_hold,
  agu_op_if.user               op,
  input  logic                 ready,
  input  logic [1:0]           fault,
  output logic                 stall,
  output logic                 mem_en,
  output logic                 io_en,
  output logic                 tlb_miss,
  output logic                 issued,
  output logic                 page_fault,
  output agu_pkg::fault_code_t fault_code,
  output agu_pkg::fault_no_t   fault_no
);
  import agu_pkg::*;

  logic       can_issue;
  logic       is_io;
  logic [1:0] fault_q;

  assign is_io     = op.op_type == OP_TYPE_IO;
  assign can_issue = op.valid & ready & ~bus_hold & ~except;

  assign mem_en = can_issue & ~is_io;
  assign io_en  = can_issue & is_io;
  assign issued = mem_en | io_en;

  // held op still waiting on translation
  assign tlb_miss = op.valid & ~ready;
  assign stall    = tlb_miss | bus_hold;

  // fault pair of the op that issued last cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      fault_q <= 2'b00;
    end else if (issued) begin
      fault_q <= fault;
    end else begin
      fault_q <= 2'b00;
    end
  end

  assign page_fault = |fault_q;
  assign fault_code = {4'b0000, fault_q[1], 2'b00, fault_q[0]};
  assign fault_no   = page_fault ? FAULT_NO_PAGE : FAULT_NO_NONE;

endmodule

// File: rtl/agu_read.sv
// load/store address read stage
`timescale 1ns/1ns
module agu_read #(
  parameter int TAG_WIDTH = $bits(agu_pkg::reg_tag_t)
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 except,
  input  logic                 bus_hold,
  input  logic                 op_en,
  input  agu_pkg::vaddr_t      op_addr,
  input  agu_pkg::size_code_t  op_sz,
  input  logic                 op_st,
  input  agu_pkg::bank_t       op_bank0,
  input  logic [TAG_WIDTH-1:0] op_tag,
  input  logic                 op_kernel,
  input  agu_pkg::op_type_t    op_type,
  output agu_pkg::vpage_t      tlb_vpage,
  output agu_pkg::vpage_t      tlb_next_vpage,
  input  logic                 tlb_hit,
  input  agu_pkg::ppage_t      tlb_phys,
  input  logic                 tlb_sys,
  input  logic                 tlb_na,
  input  logic                 tlb_next_hit,
  input  agu_pkg::ppage_t      tlb_next_phys,
  input  logic                 tlb_next_sys,
  input  logic                 tlb_next_na,
  output logic                 stall,
  output logic                 mem_en,
  output logic                 io_en,
  output logic                 tlb_miss,
  output agu_pkg::line_addr_t  addr_even,
  output agu_pkg::line_addr_t  addr_odd,
  output logic [1:0]           addr_low,
  output logic                 odd,
  output logic                 split,
  output agu_pkg::bank_mask_t  banks,
  output agu_pkg::size_code_t  sz,
  output logic                 st,
  output logic [TAG_WIDTH-1:0] tag,
  output logic                 page_fault,
  output agu_pkg::fault_code_t fault_code,
  output agu_pkg::fault_no_t   fault_no
);
  import agu_pkg::*;

  logic       ready;
  logic       issued;
  logic [1:0] fault;

  agu_op_if #(.TAG_WIDTH(TAG_WIDTH)) op_bus ();

  // decode
  agu_op_reg #(.TAG_WIDTH(TAG_WIDTH)) op_reg0 (
    .clk       (clk),
    .rst       (rst),
    .except    (except),
    .stall     (stall),
    .op_en     (op_en),
    .op_addr   (op_addr),
    .op_sz     (op_sz),
    .op_st     (op_st),
    .op_bank0  (op_bank0),
    .op_tag    (op_tag),
    .op_kernel (op_kernel),
    .op_type   (op_type),
    .issued    (issued),
    .op        (op_bus.ctl)
  );

  agu_bank_decode bank_dec0 (
    .op    (op_bus.user),
    .banks (banks)
  );

  // execute
  agu_translate xlate0 (
    .op             (op_bus.user),
    .tlb_vpage      (tlb_vpage),
    .tlb_next_vpage (tlb_next_vpage),
    .tlb_hit        (tlb_hit),
    .tlb_phys       (tlb_phys),
    .tlb_sys        (tlb_sys),
    .tlb_na         (tlb_na),
    .tlb_next_hit   (tlb_next_hit),
    .tlb_next_phys  (tlb_next_phys),
    .tlb_next_sys   (tlb_next_sys),
    .tlb_next_na    (tlb_next_na),
    .addr_even      (addr_even),
    .addr_odd       (addr_odd),
    .addr_low       (addr_low),
    .odd            (odd),
    .split          (split),
    .ready          (ready),
    .fault          (fault)
  );

  // result
  agu_issue issue0 (
    .clk        (clk),
    .rst        (rst),
    .except     (except),
    .bus_hold   (bus_hold),
    .op         (op_bus.user),
    .ready      (ready),
    .fault      (fault),
    .stall      (stall),
    .mem_en     (mem_en),
    .io_en      (io_en),
    .tlb_miss   (tlb_miss),
    .issued     (issued),
    .page_fault (page_fault),
    .fault_code (fault_code),
    .fault_no   (fault_no)
  );

  assign sz  = op_bus.sz;
  assign st  = op_bus.st;
  assign tag = op_bus.tag;

endmodule

// File: tests/agu_read_checker.sv
// read stage control assertions
`timescale 1ns/1ns
module agu_read_checker (
  input logic clk,
  input logic rst,
  input logic bus_hold,
  input logic stall,
  input logic mem_en,
  input logic io_en,
  input logic tlb_miss,
  input logic page_fault
);

  int fail_count = 0;

  // one kind of issue per cycle
  one_issue_kind: assert property (@(posedge clk) disable iff (rst) !(mem_en && io_en))
    else begin
      fail_count++;
      $error("mem_en and io_en high together");
    end

  // bus hold blocks every issue
  hold_blocks_issue: assert property (@(posedge clk) disable iff (rst)
    bus_hold |-> !(mem_en || io_en))
    else begin
      fail_count++;
      $error("issue while bus_hold is high");
    end

  miss_stalls: assert property (@(posedge clk) disable iff (rst) tlb_miss |-> stall)
    else begin
      fail_count++;
      $error("tlb_miss without stall");
    end

  // fault report belongs to the previous issue cycle
  fault_after_issue: assert property (@(posedge clk) disable iff (rst)
    page_fault |-> $past(mem_en || io_en))
    else begin
      fail_count++;
      $error("page_fault without an issue in the cycle before");
    end

endmodule

bind agu_read agu_read_checker chk0 (.*);

// File: tests/agu_read_tb.sv
// address read stage testbench
`timescale 1ns/1ns
module agu_read_tb;
  import agu_pkg::*;

  localparam int          OP_TARGET   = 3000;
  localparam int          CYCLE_LIMIT = OP_TARGET * 8;
  localparam logic [30:0] PHYS_XOR    = 31'h5a3c1e97;
  localparam logic [30:0] PAGE_BASE   = 31'h12345670;

  logic        clk = 1'b0;
  logic        rst, except, bus_hold, op_en, op_st, op_kernel;
  vaddr_t      op_addr;
  size_code_t  op_sz, sz;
  bank_t       op_bank0;
  logic [8:0]  op_tag, tag, fault_no;
  op_type_t    op_type;
  vpage_t      tlb_vpage, tlb_next_vpage;
  ppage_t      tlb_phys, tlb_next_phys;
  logic        tlb_hit, tlb_sys, tlb_na, tlb_next_hit, tlb_next_sys, tlb_next_na;
  logic        stall, mem_en, io_en, tlb_miss, odd, split, st, page_fault;
  line_addr_t  addr_even, addr_odd;
  logic [1:0]  addr_low;
  bank_mask_t  banks;
  fault_code_t fault_code;

  // tlb contents and pending fill
  vpage_t      tlb_page [16];
  logic [15:0] tlb_ok;
  int          fill_slot, fill_wait;
  vpage_t      fill_vp;
  logic        fill_two;

  // reference copy of the held op
  logic        m_valid, m_st, m_kernel;
  vaddr_t      m_addr;
  size_code_t  m_sz;
  bank_t       m_bank0;
  logic [8:0]  m_tag;
  op_type_t    m_type;
  logic [1:0]  exp_fault;

  int seed, n_checks, n_errors, n_accept, n_issue, cycle_count;

  agu_read #(.TAG_WIDTH(9)) dut0 (.*);

  always #50 clk = ~clk;

  function automatic int span_of(input size_code_t code, input logic [1:0] low);
    int cls;
    case (code)
      5'd16: cls = 0;
      5'd17: cls = 1;
      5'd18, 5'd4, 5'd5, 5'd6: cls = 2;
      5'd3: cls = 4;
      5'd0, 5'd1, 5'd2, 5'd12, 5'd13, 5'd14: cls = 5;
      5'd15: cls = 6;
      default: cls = 3;
    endcase
    case (cls)
      0: return 0;
      1: return (&low) ? 1 : 0;
      2: return (|low) ? 1 : 0;
      3: return (|low) ? 2 : 1;
      4: return (&low) ? 3 : 2;
      5: return (|low) ? 4 : 3;
      default: return 4;
    endcase
  endfunction

  function automatic bank_mask_t mask_of(input bank_t first, input int extra);
    bank_mask_t mask;
    mask = '0;
    for (int k = 0; k <= extra; k++) begin
      mask[(int'(first) + k) % 32] = 1'b1;
    end
    return mask;
  endfunction

  function automatic logic in_tlb(input vpage_t vp);
    for (int i = 0; i < 16; i++) begin
      if (tlb_ok[i] && tlb_page[i] == vp) return 1'b1;
    end
    return 1'b0;
  endfunction

  // privilege in bit 1, not present in bit 0
  function automatic logic [1:0] fault_pair(input vpage_t vp, input logic kernel);
    return {~kernel & vp[2], vp[1:0] == 2'd3};
  endfunction

  // tlb answers in the same cycle
  always_comb begin
    tlb_hit       = in_tlb(tlb_vpage);
    tlb_next_hit  = in_tlb(tlb_next_vpage);
    tlb_phys      = tlb_vpage ^ PHYS_XOR;
    tlb_next_phys = tlb_next_vpage ^ PHYS_XOR;
    tlb_sys       = tlb_vpage[2];
    tlb_next_sys  = tlb_next_vpage[2];
    tlb_na        = tlb_vpage[1:0] != 2'd3;
    tlb_next_na   = tlb_next_vpage[1:0] != 2'd3;
  end

  task automatic compare_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    n_checks++;
    assert (got === exp) else begin
      n_errors++;
      $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    logic [12:0] offs;
    r    = $random(seed);
    offs = r[12:0];
    // push some ops to the last half line of a page
    if (r[14:13] == 2'd0) offs[12:7] = 6'h3f;
    op_addr   <= {PAGE_BASE + 31'(r[17:15]), offs};
    op_en     <= r[19:18] != 2'd0;
    op_kernel <= r[20];
    op_st     <= r[21];
    bus_hold  <= r[24:22] == 3'd0;
    except    <= r[29:25] == 5'd0;
    r         = $random(seed);
    op_sz     <= r[4:0];
    op_bank0  <= r[9:5];
    op_tag    <= r[18:10];
    op_type   <= r[20:19];
    if (r[27:21] == 7'd0) tlb_ok <= '0;
    if (fill_wait > 0) begin
      fill_wait--;
      if (fill_wait == 0) begin
        tlb_page[fill_slot] <= fill_vp;
        tlb_ok[fill_slot]   <= 1'b1;
        fill_slot = (fill_slot + 1) % 16;
        if (fill_two) begin
          tlb_page[fill_slot] <= fill_vp + 1'b1;
          tlb_ok[fill_slot]   <= 1'b1;
          fill_slot = (fill_slot + 1) % 16;
        end
      end
    end
  endtask

  task automatic check_cycle();
    vpage_t     vp, vp_next;
    int         extra;
    logic       exp_split, need_next, ready, issue, exp_miss, exp_stall;
    logic [5:0] n;
    line_addr_t main_line, next_line;
    vp        = m_addr[43:13];
    vp_next   = vp + 1'b1;
    extra     = span_of(m_sz, m_addr[1:0]);
    exp_split = int'(m_bank0) + extra > 31;
    need_next = exp_split & (&m_addr[12:7]);
    ready     = in_tlb(vp) && (!need_next || in_tlb(vp_next));
    exp_miss  = m_valid & ~ready;
    exp_stall = exp_miss | bus_hold;
    issue     = m_valid & ready & ~bus_hold & ~except;
    n         = m_addr[12:7] + 6'd1;
    main_line = {vp ^ PHYS_XOR, m_addr[12:8]};
    next_line = {(need_next ? vp_next : vp) ^ PHYS_XOR, n[5:1]};
    compare_field("stall", stall, exp_stall);
    compare_field("tlb_miss", tlb_miss, exp_miss);
    compare_field("mem_en", mem_en, issue && m_type != 2'd2);
    compare_field("io_en", io_en, issue && m_type == 2'd2);
    compare_field("page_fault", page_fault, |exp_fault);
    compare_field("fault_code", fault_code,
                  (exp_fault[1] ? 8'h08 : 8'h00) | (exp_fault[0] ? 8'h01 : 8'h00));
    compare_field("fault_no", fault_no, (|exp_fault) ? 9'd45 : 9'd2);
    if (m_valid) begin
      compare_field("tlb_vpage", tlb_vpage, vp);
      compare_field("tlb_next_vpage", tlb_next_vpage, vp_next);
      compare_field("banks", banks, mask_of(m_bank0, extra));
      compare_field("split", split, exp_split);
      compare_field("odd", odd, m_addr[7]);
      compare_field("addr_low", addr_low, m_addr[1:0]);
      compare_field("addr_even", addr_even, m_addr[7] ? next_line : main_line);
      compare_field("addr_odd", addr_odd, m_addr[7] ? main_line : next_line);
      compare_field("sz", sz, m_sz);
      compare_field("st", st, m_st);
      compare_field("tag", tag, m_tag);
    end
    // miss seen, fill one to three cycles later
    if (tlb_miss && fill_wait == 0) begin
      fill_wait = 1 + int'($unsigned($random(seed)) % 3);
      fill_vp   = vp;
      fill_two  = need_next;
    end
    exp_fault = 2'b00;
    if (issue) begin
      n_issue++;
      exp_fault = fault_pair(vp, m_kernel) | (need_next ? fault_pair(vp_next, m_kernel) : 2'b00);
    end
    // stage contents for the next cycle
    if (op_en && !exp_stall && !except) begin
      n_accept++;
      m_valid  = 1'b1;
      m_addr   = op_addr;
      m_sz     = op_sz;
      m_st     = op_st;
      m_bank0  = op_bank0;
      m_tag    = op_tag;
      m_kernel = op_kernel;
      m_type   = op_type;
    end else if (except || issue) begin
      m_valid = 1'b0;
    end
  endtask

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: only %0d of %0d ops accepted within %0d cycles",
             n_accept, OP_TARGET, CYCLE_LIMIT);
    $display("errors: %0d of %0d checks, %0d assertion failures",
             n_errors, n_checks, dut0.chk0.fail_count);
    $display("Regression failed");
    $finish;
  end

  initial begin
    seed      = 32'hf5292228;
    rst       = 1'b1;
    except    = 1'b0;
    bus_hold  = 1'b0;
    op_en     = 1'b0;
    op_addr   = '0;
    op_sz     = '0;
    op_st     = 1'b0;
    op_bank0  = '0;
    op_tag    = '0;
    op_kernel = 1'b0;
    op_type   = '0;
    tlb_ok    = '0;
    fill_slot = 0;
    fill_wait = 0;
    fill_two  = 1'b0;
    m_valid   = 1'b0;
    exp_fault = 2'b00;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    compare_field("stall", stall, 1'b0);
    compare_field("mem_en", mem_en, 1'b0);
    compare_field("io_en", io_en, 1'b0);
    compare_field("tlb_miss", tlb_miss, 1'b0);
    compare_field("page_fault", page_fault, 1'b0);
    while (n_accept < OP_TARGET) begin
      @(posedge clk);
      drive_inputs();
      @(negedge clk);
      check_cycle();
    end
    $display("errors: %0d of %0d checks, %0d assertion failures, %0d ops issued",
             n_errors, n_checks, dut0.chk0.fail_count, n_issue);
    if (n_errors + dut0.chk0.fail_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: tb.f
rtl/agu_pkg.sv
rtl/agu_op_if.sv
rtl/agu_op_reg.sv
rtl/agu_bank_decode.sv
rtl/agu_translate.sv
rtl/agu_issue.sv
rtl/agu_read.sv
tests/agu_read_checker.sv
tests/agu_read_tb.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module agu_read_tb -f tb.f

run: compile
	@out=$$(./obj_dir/Vagu_read_tb +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir
